// File: bench/rob_props.sv
`timescale 1ns/1ps
// concurrent checks on the reorder buffer, bound into reorder_buffer
// occupancy bound, no tail movement while full, one branch per retire
module rob_props #(
  parameter int DEPTH = 16
) (
  input logic                                             clk,
  input logic                                             rst_n,
  input logic                                             flush,
  input logic                                             alloc_ready,
  input logic [$clog2(DEPTH):0]                           tail_q,
  input logic [$clog2(DEPTH):0]                           count_q,
  input rob_pkg::rob_entry_s [rob_pkg::COMMIT_WIDTH-1:0]  head_entry,
  input logic [1:0]                                       retire_cnt
);

  localparam int PTR_W = $clog2(DEPTH) + 1;

  a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    count_q <= PTR_W'(DEPTH))
    else $error("buffer occupancy above depth");

  // tail only moves when the buffer can take a bundle
  a_no_alloc_full: assert property (@(posedge clk) disable iff (!rst_n)
    (!alloc_ready && !flush) |=> (tail_q == $past(tail_q)))
    else $error("allocation taken while alloc_ready low");

  a_one_branch: assert property (@(posedge clk) disable iff (!rst_n)
    (retire_cnt == 2'd2) |-> !(head_entry[0].kind == rob_pkg::BRANCH &&
                               head_entry[1].kind == rob_pkg::BRANCH))
    else $error("two branches retired in one cycle");

endmodule

bind reorder_buffer rob_props #(.DEPTH(DEPTH)) u_props (
  .clk(clk), .rst_n(rst_n), .flush(flush), .alloc_ready(alloc_ready),
  .tail_q(tail_q), .count_q(count_q), .head_entry(head_entry), .retire_cnt(retire_cnt)
);

// File: bench/rob_tb.sv
`timescale 1ns/1ps
// testbench for the reorder buffer slice
// random two-wide instruction stream, random out-of-order write-backs,
// and a program-order model that checks retire, redirect, exception,
// flush, mem ready and dispatch backpressure
module rob_tb;

  localparam int DEPTH   = 16;
  localparam int IDX_W   = $clog2(DEPTH);
  localparam int N_INSTR = 5000;
  localparam int LIMIT   = 20 * N_INSTR;

  typedef struct {
    logic [rob_pkg::PC_W-1:0]    pc;
    logic [rob_pkg::REG_W-1:0]   dest;
    rob_pkg::kind_e              kind;
    logic                        exc;
    logic [rob_pkg::ECODE_W-1:0] ecode;
  } instr_t;

  logic                              clk;
  logic                              rst_n;
  logic [1:0]                        in_valid;
  logic [1:0][rob_pkg::PC_W-1:0]     in_pc;
  rob_pkg::kind_e [1:0]              in_kind;
  logic [1:0][rob_pkg::REG_W-1:0]    in_dest;
  logic [1:0]                        in_exc;
  logic [1:0][rob_pkg::ECODE_W-1:0]  in_ecode;
  logic                              in_ready;
  logic [1:0]                        issue_valid;
  logic [1:0][IDX_W-1:0]             issue_idx;
  rob_pkg::kind_e [1:0]              issue_kind;
  logic                              alu_wb_valid;
  logic [IDX_W-1:0]                  alu_wb_idx;
  logic                              alu_wb_redirect;
  logic [rob_pkg::PC_W-1:0]          alu_wb_target;
  logic                              mem_wb_valid;
  logic [IDX_W-1:0]                  mem_wb_idx;
  logic                              mem_wb_exc;
  logic [rob_pkg::ECODE_W-1:0]       mem_wb_ecode;
  logic [rob_pkg::PC_W-1:0]          mem_wb_vaddr;
  logic                              mem_wb_ready;
  logic [1:0]                        ret_valid;
  logic [1:0][rob_pkg::PC_W-1:0]     ret_pc;
  logic [1:0][rob_pkg::REG_W-1:0]    ret_dest;
  logic                              redirect_valid;
  logic [rob_pkg::PC_W-1:0]          redirect_target;
  logic                              exc_valid;
  logic [rob_pkg::ECODE_W-1:0]       exc_ecode;
  logic                              flush;

  // per-slot model state
  instr_t                    slot_ins    [DEPTH];
  bit                        slot_done   [DEPTH];
  bit                        slot_redir  [DEPTH];
  bit                        slot_exc    [DEPTH];
  logic [rob_pkg::PC_W-1:0]  slot_target [DEPTH];
  rob_pkg::rob_exc_s         slot_excv   [DEPTH];

  instr_t sent_q [$];
  int     order_q [$];
  int     alu_q [$];
  int     mem_q [$];
  int     val_errs;
  int     other_errs;
  int     cycle;
  int     gen;
  int     next_slot;
  bit     bundle_live;
  bit     timed_out;
  bit     done;
  bit     take;

  rob_top #(.DEPTH(DEPTH)) dut (.*);

  assign flush = dut.flush;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

// ==========================================================================
// compare tasks
// ==========================================================================
  task automatic check_retire(input int lane, input logic [rob_pkg::PC_W-1:0] got_pc,
                              input logic [rob_pkg::PC_W-1:0] exp_pc,
                              input logic [rob_pkg::REG_W-1:0] got_dest,
                              input logic [rob_pkg::REG_W-1:0] exp_dest);
    if (got_pc !== exp_pc) begin
      val_errs++;
      $display("mismatch ret_pc[%0d] got %h exp %h", lane, got_pc, exp_pc);
    end
    if (got_dest !== exp_dest) begin
      val_errs++;
      $display("mismatch ret_dest[%0d] got %h exp %h", lane, got_dest, exp_dest);
    end
  endtask

  task automatic check_redirect(input logic [rob_pkg::PC_W-1:0] got,
                                input logic [rob_pkg::PC_W-1:0] exp);
    if (got !== exp) begin
      val_errs++;
      $display("mismatch redirect_target got %h exp %h", got, exp);
    end
  endtask

  task automatic check_exc(input logic [rob_pkg::ECODE_W-1:0] got,
                           input logic [rob_pkg::ECODE_W-1:0] exp);
    if (got !== exp) begin
      val_errs++;
      $display("mismatch exc_ecode got %h exp %h", got, exp);
    end
  endtask

  task automatic check_issue(input int lane, input logic [IDX_W-1:0] got_idx,
                             input logic [IDX_W-1:0] exp_idx,
                             input rob_pkg::kind_e got_kind,
                             input rob_pkg::kind_e exp_kind);
    if (got_idx !== exp_idx) begin
      val_errs++;
      $display("mismatch issue_idx[%0d] got %h exp %h", lane, got_idx, exp_idx);
    end
    if (got_kind !== exp_kind) begin
      val_errs++;
      $display("mismatch issue_kind[%0d] got %h exp %h", lane, got_kind, exp_kind);
    end
  endtask

  task automatic check_lanes(input string name, input logic [1:0] got,
                             input logic [1:0] exp);
    if (got !== exp) begin
      val_errs++;
      $display("mismatch %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      val_errs++;
      $display("mismatch %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic fail_other(input string msg);
    other_errs++;
    $display("error at cycle %0d: %s", cycle, msg);
  endtask

// ==========================================================================
// model update from pre-edge outputs
// ==========================================================================
  task automatic observe();
    int         idx;
    int         last;
    bit         any;
    bit         exp_redir;
    bit         exp_exc;
    bit         exp_ready;
    logic [1:0] exp_issue;
    instr_t     it;
    last = 0;
    any  = 0;
    for (int l = 0; l < 2; l++) begin
      if (ret_valid[l] && order_q.size() == 0) begin
        fail_other("retire with no instruction outstanding");
      end else if (ret_valid[l]) begin
        idx = order_q.pop_front();
        check_retire(l, ret_pc[l], slot_ins[idx].pc, ret_dest[l], slot_ins[idx].dest);
        if (!slot_done[idx] && !slot_ins[idx].exc) begin
          fail_other("instruction retired before write-back");
        end
        if (any && (slot_ins[last].kind == rob_pkg::BRANCH || slot_redir[last] ||
                    slot_exc[last] || slot_exc[idx])) begin
          fail_other("lane 1 retired past a branch, redirect or exception");
        end
        last = idx;
        any  = 1;
      end
    end
    exp_redir = any && slot_redir[last];
    exp_exc   = any && slot_exc[last];
    check_flag("redirect_valid", redirect_valid, exp_redir);
    check_flag("exc_valid", exc_valid, exp_exc);
    check_flag("flush", flush, exp_redir | exp_exc);
    if (exp_redir) check_redirect(redirect_target, slot_target[last]);
    if (exp_exc) check_exc(exc_ecode, slot_excv[last].ecode);
    // stores wait for the head, loads never wait
    if (mem_wb_valid) begin
      idx = int'(mem_wb_idx);
      check_flag("mem_wb_ready", mem_wb_ready, slot_ins[idx].kind == rob_pkg::LOAD ||
                 (order_q.size() > 0 && order_q[0] == idx));
      if (mem_wb_ready) begin
        slot_done[idx] = 1;
        for (int k = mem_q.size() - 1; k >= 0; k--) begin
          if (mem_q[k] == idx) mem_q.delete(k);
        end
      end
    end
    if (alu_wb_valid) slot_done[int'(alu_wb_idx)] = 1;
    // held bundle goes out whole once the buffer has two free slots
    exp_issue = 2'b00;
    if (!flush && order_q.size() <= DEPTH - 2) begin
      exp_issue = (sent_q.size() == 2) ? 2'b11 : ((sent_q.size() == 1) ? 2'b01 : 2'b00);
    end
    check_lanes("issue_valid", issue_valid, exp_issue);
    exp_ready = cycle > 1 && !flush &&
                (sent_q.size() == 0 || order_q.size() <= DEPTH - 2);
    check_flag("in_ready", in_ready, exp_ready);
    for (int l = 0; l < 2; l++) begin
      if (issue_valid[l] && sent_q.size() == 0) begin
        fail_other("issue with no bundle held");
      end else if (issue_valid[l]) begin
        it  = sent_q.pop_front();
        idx = int'(issue_idx[l]);
        check_issue(l, issue_idx[l], IDX_W'(next_slot), issue_kind[l], it.kind);
        next_slot             = (next_slot + 1) % DEPTH;
        slot_ins[idx]         = it;
        slot_done[idx]        = 0;
        slot_redir[idx]       = 0;
        slot_exc[idx]         = it.exc;
        slot_excv[idx]        = '0;
        slot_excv[idx].ecode  = it.ecode;
        order_q.push_back(idx);
        if (!it.exc && (it.kind == rob_pkg::LOAD || it.kind == rob_pkg::STORE)) begin
          mem_q.push_back(idx);
        end else if (!it.exc) begin
          alu_q.push_back(idx);
        end
      end
    end
    for (int l = 0; l < 2; l++) begin
      if (in_ready && in_valid[l]) begin
        it.pc    = in_pc[l];
        it.dest  = in_dest[l];
        it.kind  = in_kind[l];
        it.exc   = in_exc[l];
        it.ecode = in_ecode[l];
        sent_q.push_back(it);
      end
    end
    if (flush) begin
      sent_q.delete();
      order_q.delete();
      alu_q.delete();
      mem_q.delete();
      next_slot = 0;
    end
  endtask

// ==========================================================================
// stimulus and execution side
// ==========================================================================
  task automatic drive(input bit new_bundle);
    logic [31:0] r;
    int          n;
    int          k;
    int          idx;
    bit          hold;
    // write-backs pause for a while so the buffer fills up
    hold = (cycle % 512) >= 448;
    if (new_bundle) begin
      n = (gen >= N_INSTR) ? 0 : int'($urandom_range(2, 0));
      gen += n;
      bundle_live = (n != 0);
      in_valid <= (n == 0) ? 2'b00 : ((n == 1) ? 2'b01 : 2'b11);
      for (int l = 0; l < 2; l++) begin
        r = $urandom;
        in_pc[l]    <= {r[31:2], 2'b00};
        r = $urandom;
        in_kind[l]  <= rob_pkg::kind_e'(r[1:0]);
        in_dest[l]  <= r[6:2];
        in_ecode[l] <= r[12:7];
        in_exc[l]   <= ($urandom_range(99, 0) < 3);
      end
    end
    if (!hold && alu_q.size() > 0) begin
      k   = int'($urandom_range(alu_q.size() - 1, 0));
      idx = alu_q[k];
      alu_q.delete(k);
      r = $urandom;
      slot_redir[idx]  = slot_ins[idx].kind == rob_pkg::BRANCH && r[2:0] == 3'd0;
      slot_target[idx] = $urandom;
      alu_wb_valid    <= 1'b1;
      alu_wb_idx      <= IDX_W'(idx);
      alu_wb_redirect <= slot_redir[idx];
      alu_wb_target   <= slot_target[idx];
    end else begin
      alu_wb_valid <= 1'b0;
    end
    // stores stay queued and get picked again until accepted
    if (!hold && mem_q.size() > 0) begin
      k   = int'($urandom_range(mem_q.size() - 1, 0));
      idx = mem_q[k];
      r = $urandom;
      slot_exc[idx]  = slot_ins[idx].kind == rob_pkg::LOAD && r[4:0] == 5'd0;
      slot_excv[idx] = $urandom;
      mem_wb_valid <= 1'b1;
      mem_wb_idx   <= IDX_W'(idx);
      mem_wb_exc   <= slot_exc[idx];
      mem_wb_ecode <= slot_excv[idx].ecode;
      mem_wb_vaddr <= $urandom;
    end else begin
      mem_wb_valid <= 1'b0;
    end
  endtask

  initial begin
    void'($urandom(10493));
    rst_n           = 1'b0;
    in_valid        = '0;
    in_pc           = '0;
    in_kind         = {rob_pkg::ALU, rob_pkg::ALU};
    in_dest         = '0;
    in_exc          = '0;
    in_ecode        = '0;
    alu_wb_valid    = 1'b0;
    alu_wb_idx      = '0;
    alu_wb_redirect = 1'b0;
    alu_wb_target   = '0;
    mem_wb_valid    = 1'b0;
    mem_wb_idx      = '0;
    mem_wb_exc      = 1'b0;
    mem_wb_ecode    = '0;
    mem_wb_vaddr    = '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    while (!done && !timed_out) begin
      @(posedge clk);
      cycle++;
      take = in_ready;
      observe();
      drive(take);
      done = gen >= N_INSTR && !bundle_live && sent_q.size() == 0 && order_q.size() == 0;
      if (cycle >= LIMIT) timed_out = 1;
    end
    if (timed_out) fail_other("run did not drain before the cycle limit");
    $display("errors: %0d mismatches, %0d other", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: run.sh
#!/bin/sh
# compile and run the reorder buffer testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module rob_tb -o rob_sim
./obj_dir/rob_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TEST OK" sim.log; then
  exit 1
fi

// File: sim.f
src/rob_pkg.sv
src/rob_dispatch.sv
src/reorder_buffer.sv
src/rob_commit.sv
src/rob_top.sv
bench/rob_props.sv
bench/rob_tb.sv

// File: src/reorder_buffer.sv
`timescale 1ns/1ps
// circular reorder buffer store with wrap-bit head and tail pointers
// allocates at the tail, marks slots complete from the alu and mem
// write-back ports and presents a two-entry head window to commit
module reorder_buffer #(
  parameter int DEPTH = 16
) (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic                                                  flush,
  input  logic [rob_pkg::DISPATCH_WIDTH-1:0]                    alloc_valid,
  input  logic [rob_pkg::DISPATCH_WIDTH-1:0][rob_pkg::PC_W-1:0] alloc_pc,
  input  rob_pkg::kind_e [rob_pkg::DISPATCH_WIDTH-1:0]          alloc_kind,
  input  logic [rob_pkg::DISPATCH_WIDTH-1:0][rob_pkg::REG_W-1:0] alloc_dest,
  input  logic [rob_pkg::DISPATCH_WIDTH-1:0]                    alloc_exc,
  input  logic [rob_pkg::DISPATCH_WIDTH-1:0][rob_pkg::ECODE_W-1:0] alloc_ecode,
  output logic                                                  alloc_ready,
  output logic [rob_pkg::DISPATCH_WIDTH-1:0][$clog2(DEPTH)-1:0] alloc_idx,
  input  logic                                                  alu_wb_valid,
  input  logic [$clog2(DEPTH)-1:0]                              alu_wb_idx,
  input  logic                                                  alu_wb_redirect,
  input  logic [rob_pkg::PC_W-1:0]                              alu_wb_target,
  input  logic                                                  mem_wb_valid,
  input  logic [$clog2(DEPTH)-1:0]                              mem_wb_idx,
  input  logic                                                  mem_wb_exc,
  input  logic [rob_pkg::ECODE_W-1:0]                           mem_wb_ecode,
  input  logic [rob_pkg::PC_W-1:0]                              mem_wb_vaddr,
  output logic                                                  mem_wb_ready,
  output rob_pkg::rob_entry_s [rob_pkg::COMMIT_WIDTH-1:0]       head_entry,
  output logic [rob_pkg::COMMIT_WIDTH-1:0]                      head_present,
  input  logic [1:0]                                            retire_cnt
);

  localparam int IDX_W = $clog2(DEPTH);
  localparam int PTR_W = IDX_W + 1;
  localparam int W     = rob_pkg::DISPATCH_WIDTH;

// ===========================================================================
// state
// ===========================================================================
  rob_pkg::rob_entry_s        entries [DEPTH];
  logic [PTR_W-1:0]           head_q;
  logic [PTR_W-1:0]           tail_q;
  logic [PTR_W-1:0]           count_q;
  logic [IDX_W-1:0]           head_idx;
  logic                       alloc_take;
  logic [1:0]                 alloc_cnt;
  rob_pkg::rob_entry_s [W-1:0] alloc_entry;

  assign head_idx    = head_q[IDX_W-1:0];
  assign alloc_ready = count_q <= PTR_W'(DEPTH - 2);
  assign alloc_take  = alloc_ready & ~flush;
  assign alloc_cnt   = alloc_take ? (2'(alloc_valid[0]) + 2'(alloc_valid[1])) : 2'd0;

  // ordered memory ops wait until they are the oldest slot
  assign mem_wb_ready = (entries[mem_wb_idx].kind == rob_pkg::LOAD) ||
                        (mem_wb_idx == head_idx);

// ===========================================================================
// allocation
// ===========================================================================
  always_comb begin
    for (int i = 0; i < W; i++) begin
      alloc_idx[i]                  = tail_q[IDX_W-1:0] + IDX_W'(i);
      alloc_entry[i]                = '0;
      // a decode exception needs no execution
      alloc_entry[i].complete       = alloc_exc[i];
      alloc_entry[i].kind           = alloc_kind[i];
      alloc_entry[i].pc             = alloc_pc[i];
      alloc_entry[i].dest           = alloc_dest[i];
      alloc_entry[i].exc            = alloc_exc[i];
      alloc_entry[i].aux.exc.ecode  = alloc_ecode[i];
      alloc_entry[i].aux.exc.badv   = alloc_pc[i][27:2];
    end
  end

  // write-backs first so a fresh allocation of the same slot wins
  always_ff @(posedge clk) begin
    if (alu_wb_valid) begin
      entries[alu_wb_idx].complete <= 1'b1;
      entries[alu_wb_idx].redirect <= alu_wb_redirect;
      if (alu_wb_redirect) begin
        entries[alu_wb_idx].aux.br_target <= alu_wb_target;
      end
    end
    if (mem_wb_valid && mem_wb_ready) begin
      entries[mem_wb_idx].complete <= 1'b1;
      entries[mem_wb_idx].exc      <= mem_wb_exc;
      if (mem_wb_exc) begin
        entries[mem_wb_idx].aux.exc.ecode <= mem_wb_ecode;
        entries[mem_wb_idx].aux.exc.badv  <= mem_wb_vaddr[27:2];
      end
    end
    if (alloc_take) begin
      for (int i = 0; i < W; i++) begin
        if (alloc_valid[i]) begin
          entries[alloc_idx[i]] <= alloc_entry[i];
        end
      end
    end
  end

// ===========================================================================
// pointers and head window
// ===========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else if (flush) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      head_q  <= head_q + PTR_W'(retire_cnt);
      tail_q  <= tail_q + PTR_W'(alloc_cnt);
      count_q <= count_q + PTR_W'(alloc_cnt) - PTR_W'(retire_cnt);
    end
  end

  always_comb begin
    for (int i = 0; i < rob_pkg::COMMIT_WIDTH; i++) begin
      head_entry[i]   = entries[head_idx + IDX_W'(i)];
      head_present[i] = count_q > PTR_W'(i);
    end
  end

endmodule

// File: src/rob_commit.sv
`timescale 1ns/1ps
// in-order retire selection over the two-entry head window
// one branch per cycle, nothing past a redirect or exception;
// retire, redirect, exception and flush outputs are registered
module rob_commit #(
  parameter int DEPTH = 16
) (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  rob_pkg::rob_entry_s [rob_pkg::COMMIT_WIDTH-1:0]      head_entry,
  input  logic [rob_pkg::COMMIT_WIDTH-1:0]                     head_present,
  output logic [1:0]                                           retire_cnt,
  output logic                                                 flush,
  output logic [rob_pkg::COMMIT_WIDTH-1:0]                     ret_valid,
  output logic [rob_pkg::COMMIT_WIDTH-1:0][rob_pkg::PC_W-1:0]  ret_pc,
  output logic [rob_pkg::COMMIT_WIDTH-1:0][rob_pkg::REG_W-1:0] ret_dest,
  output logic                                                 redirect_valid,
  output logic [rob_pkg::PC_W-1:0]                             redirect_target,
  output logic                                                 exc_valid,
  output logic [rob_pkg::ECODE_W-1:0]                          exc_ecode
);

  // head window of two must fit in a power-of-two ring
  if (DEPTH < 4 || (DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
    $error("rob_commit: DEPTH must be a power of two of at least 4");
  end

  logic [rob_pkg::COMMIT_WIDTH-1:0] retire;
  rob_pkg::rob_entry_s              last;
  logic                             do_redirect;
  logic                             do_exc;

  // no retire while a flush is in flight
  always_comb begin
    retire[0] = head_present[0] & head_entry[0].complete & ~flush;
    retire[1] = retire[0] & head_present[1] & head_entry[1].complete &
                (head_entry[0].kind != rob_pkg::BRANCH) &
                ~head_entry[0].redirect & ~head_entry[0].exc &
                ~head_entry[1].exc;
    last        = retire[1] ? head_entry[1] : head_entry[0];
    do_redirect = retire[0] & last.redirect;
    do_exc      = retire[0] & last.exc;
  end

  assign retire_cnt = 2'(retire[0]) + 2'(retire[1]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ret_valid      <= '0;
      redirect_valid <= 1'b0;
      exc_valid      <= 1'b0;
      flush          <= 1'b0;
    end else begin
      ret_valid      <= retire;
      redirect_valid <= do_redirect;
      exc_valid      <= do_exc;
      flush          <= do_redirect | do_exc;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < rob_pkg::COMMIT_WIDTH; i++) begin
      ret_pc[i]   <= head_entry[i].pc;
      ret_dest[i] <= head_entry[i].dest;
    end
    redirect_target <= last.aux.br_target;
    exc_ecode       <= last.aux.exc.ecode;
  end

endmodule

// File: src/rob_dispatch.sv
`timescale 1ns/1ps
// dispatch stage register for a two-wide bundle
// holds the bundle while the buffer is full, clears on flush and
// republishes the allocated slot indices to the execution side
module rob_dispatch #(
  parameter int DEPTH = 16
) (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic [rob_pkg::DISPATCH_WIDTH-1:0]                    in_valid,
  input  logic [rob_pkg::DISPATCH_WIDTH-1:0][rob_pkg::PC_W-1:0] in_pc,
  input  rob_pkg::kind_e [rob_pkg::DISPATCH_WIDTH-1:0]          in_kind,
  input  logic [rob_pkg::DISPATCH_WIDTH-1:0][rob_pkg::REG_W-1:0] in_dest,
  input  logic [rob_pkg::DISPATCH_WIDTH-1:0]                    in_exc,
  input  logic [rob_pkg::DISPATCH_WIDTH-1:0][rob_pkg::ECODE_W-1:0] in_ecode,
  output logic                                                  in_ready,
  input  logic                                                  flush,
  input  logic                                                  alloc_ready,
  input  logic [rob_pkg::DISPATCH_WIDTH-1:0][$clog2(DEPTH)-1:0] alloc_idx,
  output logic [rob_pkg::DISPATCH_WIDTH-1:0]                    alloc_valid,
  output logic [rob_pkg::DISPATCH_WIDTH-1:0][rob_pkg::PC_W-1:0] alloc_pc,
  output rob_pkg::kind_e [rob_pkg::DISPATCH_WIDTH-1:0]          alloc_kind,
  output logic [rob_pkg::DISPATCH_WIDTH-1:0][rob_pkg::REG_W-1:0] alloc_dest,
  output logic [rob_pkg::DISPATCH_WIDTH-1:0]                    alloc_exc,
  output logic [rob_pkg::DISPATCH_WIDTH-1:0][rob_pkg::ECODE_W-1:0] alloc_ecode,
  output logic [rob_pkg::DISPATCH_WIDTH-1:0]                    issue_valid,
  output logic [rob_pkg::DISPATCH_WIDTH-1:0][$clog2(DEPTH)-1:0] issue_idx,
  output rob_pkg::kind_e [rob_pkg::DISPATCH_WIDTH-1:0]          issue_kind
);

  localparam int W = rob_pkg::DISPATCH_WIDTH;

  logic                               started_q;
  logic [W-1:0]                       valid_q;
  logic [W-1:0][rob_pkg::PC_W-1:0]    pc_q;
  rob_pkg::kind_e [W-1:0]             kind_q;
  logic [W-1:0][rob_pkg::REG_W-1:0]   dest_q;
  logic [W-1:0]                       exc_q;
  logic [W-1:0][rob_pkg::ECODE_W-1:0] ecode_q;
  logic                               taken;

  // the buffer takes the held bundle unless it is full or flushing
  assign taken    = alloc_ready & ~flush;
  assign in_ready = started_q & ~flush & (~|valid_q | alloc_ready);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      started_q <= 1'b0;
      valid_q   <= '0;
    end else begin
      started_q <= 1'b1;
      if (flush) begin
        valid_q <= '0;
      end else if (in_ready) begin
        valid_q <= in_valid;
      end
    end
  end

  // bundle payload, held while stalled
  always_ff @(posedge clk) begin
    if (in_ready) begin
      pc_q    <= in_pc;
      kind_q  <= in_kind;
      dest_q  <= in_dest;
      exc_q   <= in_exc;
      ecode_q <= in_ecode;
    end
  end

  assign alloc_valid = valid_q;
  assign alloc_pc    = pc_q;
  assign alloc_kind  = kind_q;
  assign alloc_dest  = dest_q;
  assign alloc_exc   = exc_q;
  assign alloc_ecode = ecode_q;

  // only lanes the buffer really allocates go to execution
  assign issue_valid = valid_q & {W{taken}};
  assign issue_idx   = alloc_idx;
  assign issue_kind  = kind_q;

endmodule

// File: src/rob_pkg.sv
// shared widths and types for the two-wide reorder buffer slice
// modules reference these by scoped name, e.g. rob_pkg::rob_entry_s
package rob_pkg;

  localparam int DISPATCH_WIDTH = 2;
  localparam int COMMIT_WIDTH   = 2;
  localparam int PC_W           = 32;
  localparam int REG_W          = 5;
  localparam int ECODE_W        = 6;
  localparam int BADV_W         = 26;

  // STORE covers every memory op that must be oldest before write-back
  typedef enum logic [1:0] {
    ALU    = 2'd0,
    LOAD   = 2'd1,
    STORE  = 2'd2,
    BRANCH = 2'd3
  } kind_e;

  // exception view, badv holds faulting vaddr bits 27:2
  typedef struct packed {
    logic [ECODE_W-1:0] ecode;
    logic [BADV_W-1:0]  badv;
  } rob_exc_s;

  // one aux word, decoded by the entry's redirect or exc bit
  typedef union packed {
    logic [PC_W-1:0] br_target;
    rob_exc_s        exc;
  } rob_aux_u;

  typedef struct packed {
    logic             complete;
    kind_e            kind;
    logic [PC_W-1:0]  pc;
    logic [REG_W-1:0] dest;
    logic             redirect;
    logic             exc;
    rob_aux_u         aux;
  } rob_entry_s;

endpackage

// File: src/rob_top.sv
`timescale 1ns/1ps
// reorder buffer slice top: dispatch stage, entry store and commit
// DEPTH is set here and handed to every stage
module rob_top #(
  parameter int DEPTH = 16
) (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic [rob_pkg::DISPATCH_WIDTH-1:0]                    in_valid,
  input  logic [rob_pkg::DISPATCH_WIDTH-1:0][rob_pkg::PC_W-1:0] in_pc,
  input  rob_pkg::kind_e [rob_pkg::DISPATCH_WIDTH-1:0]          in_kind,
  input  logic [rob_pkg::DISPATCH_WIDTH-1:0][rob_pkg::REG_W-1:0] in_dest,
  input  logic [rob_pkg::DISPATCH_WIDTH-1:0]                    in_exc,
  input  logic [rob_pkg::DISPATCH_WIDTH-1:0][rob_pkg::ECODE_W-1:0] in_ecode,
  output logic                                                  in_ready,
  output logic [rob_pkg::DISPATCH_WIDTH-1:0]                    issue_valid,
  output logic [rob_pkg::DISPATCH_WIDTH-1:0][$clog2(DEPTH)-1:0] issue_idx,
  output rob_pkg::kind_e [rob_pkg::DISPATCH_WIDTH-1:0]          issue_kind,
  input  logic                                                  alu_wb_valid,
  input  logic [$clog2(DEPTH)-1:0]                              alu_wb_idx,
  input  logic                                                  alu_wb_redirect,
  input  logic [rob_pkg::PC_W-1:0]                              alu_wb_target,
  input  logic                                                  mem_wb_valid,
  input  logic [$clog2(DEPTH)-1:0]                              mem_wb_idx,
  input  logic                                                  mem_wb_exc,
  input  logic [rob_pkg::ECODE_W-1:0]                           mem_wb_ecode,
  input  logic [rob_pkg::PC_W-1:0]                              mem_wb_vaddr,
  output logic                                                  mem_wb_ready,
  output logic [rob_pkg::COMMIT_WIDTH-1:0]                      ret_valid,
  output logic [rob_pkg::COMMIT_WIDTH-1:0][rob_pkg::PC_W-1:0]   ret_pc,
  output logic [rob_pkg::COMMIT_WIDTH-1:0][rob_pkg::REG_W-1:0]  ret_dest,
  output logic                                                  redirect_valid,
  output logic [rob_pkg::PC_W-1:0]                              redirect_target,
  output logic                                                  exc_valid,
  output logic [rob_pkg::ECODE_W-1:0]                           exc_ecode
);

  localparam int W = rob_pkg::DISPATCH_WIDTH;

  logic                                   flush;
  logic                                   alloc_ready;
  logic [W-1:0][$clog2(DEPTH)-1:0]        alloc_idx;
  logic [W-1:0]                           alloc_valid;
  logic [W-1:0][rob_pkg::PC_W-1:0]        alloc_pc;
  rob_pkg::kind_e [W-1:0]                 alloc_kind;
  logic [W-1:0][rob_pkg::REG_W-1:0]       alloc_dest;
  logic [W-1:0]                           alloc_exc;
  logic [W-1:0][rob_pkg::ECODE_W-1:0]     alloc_ecode;
  rob_pkg::rob_entry_s [rob_pkg::COMMIT_WIDTH-1:0] head_entry;
  logic [rob_pkg::COMMIT_WIDTH-1:0]       head_present;
  logic [1:0]                             retire_cnt;

  rob_dispatch #(.DEPTH(DEPTH)) u_dispatch (
    .clk, .rst_n, .in_valid, .in_pc, .in_kind, .in_dest, .in_exc, .in_ecode,
    .in_ready, .flush, .alloc_ready, .alloc_idx, .alloc_valid, .alloc_pc,
    .alloc_kind, .alloc_dest, .alloc_exc, .alloc_ecode,
    .issue_valid, .issue_idx, .issue_kind
  );

  reorder_buffer #(.DEPTH(DEPTH)) u_rob (
    .clk, .rst_n, .flush, .alloc_valid, .alloc_pc, .alloc_kind, .alloc_dest,
    .alloc_exc, .alloc_ecode, .alloc_ready, .alloc_idx,
    .alu_wb_valid, .alu_wb_idx, .alu_wb_redirect, .alu_wb_target,
    .mem_wb_valid, .mem_wb_idx, .mem_wb_exc, .mem_wb_ecode, .mem_wb_vaddr,
    .mem_wb_ready, .head_entry, .head_present, .retire_cnt
  );

  rob_commit #(.DEPTH(DEPTH)) u_commit (
    .clk, .rst_n, .head_entry, .head_present, .retire_cnt, .flush,
    .ret_valid, .ret_pc, .ret_dest, .redirect_valid, .redirect_target,
    .exc_valid, .exc_ecode
  );

endmodule
